// File: project.f
spi_pkg.sv
spi_clkgen.sv
spi_tx_shifter.sv
spi_rx_shifter.sv
spi_sequencer.sv
spi_master.sv
tb_spi_master.sv

// File: spi_clkgen.sv
// spi_clk half-period is clk_div+1 cycles; a divider change applies from the next count
`timescale 1ns/1ps

module spi_clkgen (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      en,
  input  logic [spi_pkg::div_w-1:0] clk_div,
  input  logic                      clk_div_valid,
  output logic                      spi_clk,
  output logic                      spi_rise,
  output logic                      spi_fall
);

  import spi_pkg::*;

  logic [div_w-1:0] div_q;
  logic [div_w-1:0] cnt_q;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      div_q    <= '0;
      cnt_q    <= '0;
      spi_clk  <= 1'b0;
      spi_rise <= 1'b0;
      spi_fall <= 1'b0;
    end
    else
    begin
      if (clk_div_valid)
        div_q <= clk_div;

      spi_rise <= 1'b0;
      spi_fall <= 1'b0;

      // a disabled divider keeps its count, so a stall resumes mid half-period
      if (en)
      begin
        if (cnt_q >= div_q)
        begin
          cnt_q    <= '0;
          spi_clk  <= ~spi_clk;
          spi_rise <= ~spi_clk;
          spi_fall <= spi_clk;
        end
        else
        begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

// File: spi_master.sv
// one transaction per start strobe; tx and rx words use valid/ready and move when both are high
`timescale 1ns/1ps

module spi_master (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic [spi_pkg::div_w-1:0]       clk_div,
  input  logic                            clk_div_valid,
  input  logic                            rd,
  input  logic                            wr,
  input  logic                            qrd,
  input  logic                            qwr,
  input  logic [spi_pkg::word_w-1:0]      cmd,
  input  logic [spi_pkg::word_w-1:0]      addr,
  input  logic [spi_pkg::phase_len_w-1:0] cmd_len,
  input  logic [spi_pkg::phase_len_w-1:0] addr_len,
  input  logic [spi_pkg::len_w-1:0]       data_len,
  input  logic [spi_pkg::len_w-1:0]       dummy_rd,
  input  logic [spi_pkg::len_w-1:0]       dummy_wr,
  input  logic [spi_pkg::cs_n-1:0]        cs_mask,
  input  logic [spi_pkg::word_w-1:0]      tx_data,
  input  logic                            tx_valid,
  output logic                            tx_ready,
  output logic [spi_pkg::word_w-1:0]      rx_data,
  output logic                            rx_valid,
  input  logic                            rx_ready,
  output logic                            spi_clk,
  output logic [spi_pkg::cs_n-1:0]        csn,
  output spi_pkg::spi_mode_t              mode,
  output logic [spi_pkg::quad_lanes-1:0]  sdo,
  input  logic [spi_pkg::quad_lanes-1:0]  sdi,
  output spi_pkg::status_t                status,
  output logic                            eot
);

  import spi_pkg::*;

  logic              spi_rise;
  logic              spi_fall;
  logic              clock_en;
  logic              cs_active;
  logic              en_tx;
  logic              en_rx;
  logic              quad;
  logic              tx_counter_upd;
  logic              rx_counter_upd;
  logic [len_w-1:0]  tx_counter;
  logic [len_w-1:0]  rx_counter;
  logic              tx_done;
  logic              rx_done;
  logic              tx_clk_en;
  logic              rx_clk_en;
  tx_src_t           tx_src;
  logic [word_w-1:0] tx_word;
  logic              tx_word_valid;
  logic              tx_word_ready;

  spi_sequencer u_seq (
    .clk            (clk),
    .rstn           (rstn),
    .rd             (rd),
    .wr             (wr),
    .qrd            (qrd),
    .qwr            (qwr),
    .cmd_len        (cmd_len),
    .addr_len       (addr_len),
    .data_len       (data_len),
    .dummy_rd       (dummy_rd),
    .dummy_wr       (dummy_wr),
    .tx_done        (tx_done),
    .rx_done        (rx_done),
    .tx_clk_en      (tx_clk_en),
    .rx_clk_en      (rx_clk_en),
    .spi_fall       (spi_fall),
    .clock_en       (clock_en),
    .cs_active      (cs_active),
    .en_tx          (en_tx),
    .en_rx          (en_rx),
    .tx_counter_upd (tx_counter_upd),
    .rx_counter_upd (rx_counter_upd),
    .quad           (quad),
    .eot            (eot),
    .tx_counter     (tx_counter),
    .rx_counter     (rx_counter),
    .tx_src         (tx_src),
    .status         (status),
    .mode           (mode)
  );

  spi_clkgen u_clkgen (
    .clk           (clk),
    .rstn          (rstn),
    .en            (clock_en),
    .clk_div       (clk_div),
    .clk_div_valid (clk_div_valid),
    .spi_clk       (spi_clk),
    .spi_rise      (spi_rise),
    .spi_fall      (spi_fall)
  );

  spi_tx_shifter u_tx (
    .clk         (clk),
    .rstn        (rstn),
    .en          (en_tx),
    .tx_edge     (spi_fall),
    .quad        (quad),
    .counter     (tx_counter),
    .counter_upd (tx_counter_upd),
    .data        (tx_word),
    .data_valid  (tx_word_valid),
    .data_ready  (tx_word_ready),
    .done        (tx_done),
    .clk_en      (tx_clk_en),
    .sdo         (sdo)
  );

  spi_rx_shifter u_rx (
    .clk         (clk),
    .rstn        (rstn),
    .en          (en_rx),
    .rx_edge     (spi_rise),
    .quad        (quad),
    .counter     (rx_counter),
    .counter_upd (rx_counter_upd),
    .sdi         (sdi),
    .data        (rx_data),
    .data_valid  (rx_valid),
    .data_ready  (rx_ready),
    .done        (rx_done),
    .clk_en      (rx_clk_en)
  );

  // command and address words are always ready, dummy bits shift out zeros
  always_comb
  begin
    tx_word       = '0;
    tx_word_valid = 1'b0;
    tx_ready      = 1'b0;
    case (tx_src)
      src_empty: tx_word_valid = 1'b1;
      src_cmd:
      begin
        tx_word       = cmd;
        tx_word_valid = 1'b1;
      end
      src_addr:
      begin
        tx_word       = addr;
        tx_word_valid = 1'b1;
      end
      src_fifo:
      begin
        tx_word       = tx_data;
        tx_word_valid = tx_valid;
        tx_ready      = tx_word_ready;
      end
      default: ;
    endcase
  end

  assign csn = ~(cs_mask & {cs_n{cs_active}});

endmodule

// File: spi_pkg.sv
// sizes and codes shared by the SPI master; lengths count bits and a data phase holds at most 65535
package spi_pkg;

  localparam int word_w      = 32;
  localparam int len_w       = 16;
  localparam int phase_len_w = 6;
  localparam int div_w       = 8;
  localparam int cs_n        = 4;
  localparam int quad_lanes  = 4;

  // bits left in a word fit from 0 up to word_w
  localparam int bit_cnt_w  = $clog2(word_w) + 1;
  localparam int lane_shift = $clog2(quad_lanes);

  // how the four data pins are used
  typedef enum logic [1:0] {
    mode_std     = 2'b00,
    mode_quad_tx = 2'b01,
    mode_quad_rx = 2'b10
  } spi_mode_t;

  typedef enum logic [2:0] {
    st_idle,
    st_cmd,
    st_addr,
    st_dummy,
    st_data_tx,
    st_data_rx,
    st_wait_edge
  } seq_state_t;

  // one bit per phase, wait_edge shows as data_rx
  typedef logic [5:0] status_t;

  localparam status_t stat_idle    = 6'b000001;
  localparam status_t stat_cmd     = 6'b000010;
  localparam status_t stat_addr    = 6'b000100;
  localparam status_t stat_dummy   = 6'b001000;
  localparam status_t stat_data_tx = 6'b010000;
  localparam status_t stat_data_rx = 6'b100000;

  typedef enum logic [2:0] {
    src_null,
    src_empty,
    src_cmd,
    src_addr,
    src_fifo
  } tx_src_t;

endpackage

// File: spi_rx_shifter.sv
// quad lengths must be multiples of four; single line mode samples sdi[1] only
`timescale 1ns/1ps

module spi_rx_shifter (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           en,
  input  logic                           rx_edge,
  input  logic                           quad,
  input  logic [spi_pkg::len_w-1:0]      counter,
  input  logic                           counter_upd,
  input  logic [spi_pkg::quad_lanes-1:0] sdi,
  output logic [spi_pkg::word_w-1:0]     data,
  output logic                           data_valid,
  input  logic                           data_ready,
  output logic                           done,
  output logic                           clk_en
);

  import spi_pkg::*;

  logic [word_w-1:0]    shift_q;
  logic [word_w-1:0]    shift_next;
  logic [len_w-1:0]     cnt_q;
  logic [bit_cnt_w-1:0] left_q;
  logic [bit_cnt_w-1:0] full;
  logic                 valid_q;
  logic                 last_q;
  logic                 sample;
  logic                 last;
  logic                 word_end;

  assign full = quad ? bit_cnt_w'(word_w / quad_lanes) : bit_cnt_w'(word_w);

  assign sample   = en && rx_edge && cnt_q != '0;
  assign last     = cnt_q == len_w'(1);
  assign word_end = left_q == bit_cnt_w'(1) || last;

  assign shift_next = quad ? {shift_q[word_w-quad_lanes-1:0], sdi} :
                             {shift_q[word_w-2:0], sdi[1]};

  assign data_valid = valid_q;
  assign done       = valid_q && data_ready && last_q;

  // stop after the final rise, and before a rise that would overwrite a waiting word
  assign clk_en = cnt_q != '0 && !(sample && last) &&
                  !(valid_q && !data_ready && word_end);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt_q   <= '0;
      left_q  <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end
    else if (counter_upd)
    begin
      cnt_q  <= quad ? counter >> lane_shift : counter;
      left_q <= full;
      last_q <= 1'b0;
    end
    else
    begin
      if (valid_q && data_ready)
      begin
        valid_q <= 1'b0;
        last_q  <= 1'b0;
      end

      if (sample)
      begin
        cnt_q  <= cnt_q - 1'b1;
        left_q <= word_end ? full : left_q - 1'b1;
        if (word_end)
        begin
          valid_q <= 1'b1;
          last_q  <= last;
        end
      end
    end
  end

  // a short final word lands in the low bits since the register starts cleared
  always_ff @(posedge clk)
  begin
    if (counter_upd)
    begin
      shift_q <= '0;
    end
    else if (sample)
    begin
      if (word_end)
      begin
        data    <= shift_next;
        shift_q <= '0;
      end
      else
      begin
        shift_q <= shift_next;
      end
    end
  end

endmodule

// File: spi_sequencer.sv
// start strobes are only seen in idle; dummy cycles run only when the data length is non-zero
`timescale 1ns/1ps

module spi_sequencer (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            rd,
  input  logic                            wr,
  input  logic                            qrd,
  input  logic                            qwr,
  input  logic [spi_pkg::phase_len_w-1:0] cmd_len,
  input  logic [spi_pkg::phase_len_w-1:0] addr_len,
  input  logic [spi_pkg::len_w-1:0]       data_len,
  input  logic [spi_pkg::len_w-1:0]       dummy_rd,
  input  logic [spi_pkg::len_w-1:0]       dummy_wr,
  input  logic                            tx_done,
  input  logic                            rx_done,
  input  logic                            tx_clk_en,
  input  logic                            rx_clk_en,
  input  logic                            spi_fall,
  output logic                            clock_en,
  output logic                            cs_active,
  output logic                            en_tx,
  output logic                            en_rx,
  output logic                            tx_counter_upd,
  output logic                            rx_counter_upd,
  output logic                            quad,
  output logic                            eot,
  output logic [spi_pkg::len_w-1:0]       tx_counter,
  output logic [spi_pkg::len_w-1:0]       rx_counter,
  output spi_pkg::tx_src_t                tx_src,
  output spi_pkg::status_t                status,
  output spi_pkg::spi_mode_t              mode
);

  import spi_pkg::*;

  seq_state_t       state_q;
  seq_state_t       state_next;
  seq_state_t       pick;
  spi_mode_t        mode_next;
  logic             start;
  logic             advance;
  logic             rx_q;
  logic             quad_q;
  logic             rx_dir;
  logic [1:0]       level;
  logic [len_w-1:0] dummy_len;

  assign start     = rd | wr | qrd | qwr;
  assign cs_active = state_q != st_idle;

  // in idle the strobes decide, later the latched copies
  assign rx_dir    = cs_active ? rx_q : (rd | qrd);
  assign quad      = cs_active ? quad_q : (qrd | qwr);
  assign dummy_len = rx_dir ? dummy_rd : dummy_wr;

  // how far the transaction has come, and whether this phase ends now
  always_comb
  begin
    level   = 2'd0;
    advance = 1'b0;
    case (state_q)
      st_idle:  advance = start;
      st_cmd:
      begin
        level   = 2'd1;
        advance = tx_done;
      end
      st_addr:
      begin
        level   = 2'd2;
        advance = tx_done;
      end
      st_dummy:
      begin
        level   = 2'd3;
        advance = tx_done;
      end
      default: ;
    endcase
  end

  // first non-empty phase after the current one
  always_comb
  begin
    pick = st_idle;
    if (level == 2'd0 && cmd_len != '0)
      pick = st_cmd;
    else if (level <= 2'd1 && addr_len != '0)
      pick = st_addr;
    else if (data_len != '0)
    begin
      if (level <= 2'd2 && dummy_len != '0)
        pick = st_dummy;
      else
        pick = rx_dir ? st_data_rx : st_data_tx;
    end
  end

  always_comb
  begin
    state_next     = state_q;
    clock_en       = 1'b0;
    en_tx          = 1'b0;
    en_rx          = 1'b0;
    tx_counter_upd = 1'b0;
    rx_counter_upd = 1'b0;
    tx_counter     = '0;
    rx_counter     = '0;
    tx_src         = src_null;
    eot            = 1'b0;

    case (state_q)
      st_cmd, st_addr, st_dummy:
      begin
        tx_src   = (state_q == st_cmd)  ? src_cmd :
                   (state_q == st_addr) ? src_addr : src_empty;
        en_tx    = 1'b1;
        clock_en = tx_clk_en;
      end
      st_data_tx:
      begin
        tx_src   = src_fifo;
        en_tx    = 1'b1;
        clock_en = tx_clk_en;
        if (tx_done)
        begin
          eot        = 1'b1;
          clock_en   = 1'b0;
          state_next = st_idle;
        end
      end
      st_data_rx:
      begin
        en_rx    = 1'b1;
        clock_en = rx_clk_en;
        if (rx_done)
          state_next = st_wait_edge;
      end
      st_wait_edge:
      begin
        // spi_clk rests high after the last sample, one fall closes the frame
        clock_en = !spi_fall;
        if (spi_fall)
        begin
          eot        = 1'b1;
          state_next = st_idle;
        end
      end
      default: ;
    endcase

    // loads for the next phase go out in the cycle the current one ends
    if (advance)
    begin
      state_next = pick;
      case (pick)
        st_cmd:
        begin
          tx_counter     = len_w'(cmd_len);
          tx_src         = src_cmd;
          tx_counter_upd = 1'b1;
          en_tx          = 1'b1;
        end
        st_addr:
        begin
          tx_counter     = len_w'(addr_len);
          tx_src         = src_addr;
          tx_counter_upd = 1'b1;
          en_tx          = 1'b1;
        end
        st_dummy:
        begin
          tx_counter     = quad ? dummy_len << lane_shift : dummy_len;
          tx_src         = src_empty;
          tx_counter_upd = 1'b1;
          en_tx          = 1'b1;
        end
        st_data_tx:
        begin
          tx_counter     = data_len;
          tx_src         = src_fifo;
          tx_counter_upd = 1'b1;
          en_tx          = 1'b1;
        end
        st_data_rx:
        begin
          rx_counter     = data_len;
          rx_counter_upd = 1'b1;
          // keep the clock running out of an earlier phase, but not out of idle
          clock_en       = cs_active;
        end
        default:
        begin
          eot      = 1'b1;
          clock_en = 1'b0;
        end
      endcase
    end
  end

  always_comb
  begin
    case (state_next)
      st_cmd, st_addr, st_data_tx:         mode_next = quad ? mode_quad_tx : mode_std;
      st_dummy, st_data_rx, st_wait_edge:  mode_next = quad ? mode_quad_rx : mode_std;
      default:                             mode_next = mode_quad_rx;
    endcase
  end

  always_comb
  begin
    case (state_q)
      st_cmd:                   status = stat_cmd;
      st_addr:                  status = stat_addr;
      st_dummy:                 status = stat_dummy;
      st_data_tx:               status = stat_data_tx;
      st_data_rx, st_wait_edge: status = stat_data_rx;
      default:                  status = stat_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q <= st_idle;
      quad_q  <= 1'b0;
      rx_q    <= 1'b0;
      mode    <= mode_quad_rx;
    end
    else
    begin
      state_q <= state_next;
      mode    <= mode_next;
      if (!cs_active && start)
      begin
        quad_q <= quad;
        rx_q   <= rx_dir;
      end
    end
  end

endmodule

// File: spi_tx_shifter.sv
// quad lengths must be multiples of four; the source must hold data valid until it is taken
`timescale 1ns/1ps

module spi_tx_shifter (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           en,
  input  logic                           tx_edge,
  input  logic                           quad,
  input  logic [spi_pkg::len_w-1:0]      counter,
  input  logic                           counter_upd,
  input  logic [spi_pkg::word_w-1:0]     data,
  input  logic                           data_valid,
  output logic                           data_ready,
  output logic                           done,
  output logic                           clk_en,
  output logic [spi_pkg::quad_lanes-1:0] sdo
);

  import spi_pkg::*;

  logic [word_w-1:0]    shift_q;
  logic [len_w-1:0]     cnt_q;
  logic [bit_cnt_w-1:0] left_q;
  logic [bit_cnt_w-1:0] full;
  logic                 shift;
  logic                 last;
  logic                 need_word;
  logic                 load;

  assign full = quad ? bit_cnt_w'(word_w / quad_lanes) : bit_cnt_w'(word_w);

  // cnt_q counts fall strobes still to come, one per bit or per nibble
  assign shift = en && tx_edge && cnt_q != '0 && left_q != '0;
  assign last  = cnt_q == len_w'(1);

  // the last bit of this word is on the pins and more bits follow
  assign need_word = left_q == bit_cnt_w'(1) && cnt_q > len_w'(1);

  assign load = data_valid &&
                (counter_upd || (en && left_q == '0 && cnt_q != '0) || (shift && need_word));

  assign data_ready = load;
  assign done       = shift && last;

  // without a next word the clock must not reach the fall that would need it
  always_comb
  begin
    if (counter_upd)
      clk_en = data_valid;
    else
      clk_en = left_q != '0 && !(need_word && !data_valid);
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt_q  <= '0;
      left_q <= '0;
    end
    else if (counter_upd)
    begin
      cnt_q  <= quad ? counter >> lane_shift : counter;
      left_q <= data_valid ? full : '0;
    end
    else
    begin
      if (shift)
        cnt_q <= cnt_q - 1'b1;

      if (load)
        left_q <= full;
      else if (shift)
        left_q <= need_word ? '0 : left_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
      shift_q <= data;
    else if (shift)
      shift_q <= quad ? shift_q << quad_lanes : shift_q << 1;
  end

  // single line mode drives only sdo[0]
  assign sdo = quad ? shift_q[word_w-1 -: quad_lanes] :
                      {{(quad_lanes-1){1'b0}}, shift_q[word_w-1]};

endmodule

// File: tb_spi_master.sv
// clk_div stays at 1 or more so sdo never shifts on a sampling edge; run ends at 20000 cycles
`timescale 1ns/1ps

module tb_spi_master;

  import spi_pkg::*;

  localparam int max_cycles = 20000;
  localparam int k_wr  = 0;
  localparam int k_rd  = 1;
  localparam int k_qwr = 2;
  localparam int k_qrd = 3;

  logic                   clk;
  logic                   rstn;
  logic [div_w-1:0]       clk_div;
  logic                   clk_div_valid;
  logic                   rd;
  logic                   wr;
  logic                   qrd;
  logic                   qwr;
  logic [word_w-1:0]      cmd;
  logic [word_w-1:0]      addr;
  logic [phase_len_w-1:0] cmd_len;
  logic [phase_len_w-1:0] addr_len;
  logic [len_w-1:0]       data_len;
  logic [len_w-1:0]       dummy_rd;
  logic [len_w-1:0]       dummy_wr;
  logic [cs_n-1:0]        cs_mask;
  logic [word_w-1:0]      tx_data;
  logic                   tx_valid;
  logic                   tx_ready;
  logic [word_w-1:0]      rx_data;
  logic                   rx_valid;
  logic                   rx_ready;
  logic                   spi_clk;
  logic [cs_n-1:0]        csn;
  spi_mode_t              mode;
  logic [quad_lanes-1:0]  sdo;
  logic [quad_lanes-1:0]  sdi;
  status_t                status;
  logic                   eot;

  integer            seed;
  int                errors;
  int                cycles;
  int                eot_cnt;
  int                rises;
  int                pre_clocks;
  int                cur_div;
  logic              cur_quad;
  logic              chk_div;
  logic              seen_toggle;
  int                since;
  logic              last_spi_clk;
  status_t           last_stat;
  int                rx_stall_rises;
  int                tx_stall_rises;
  logic              tx_stall;
  logic              rx_stall;
  logic              tx_took;
  int                tx_idx;
  int                tx_n;
  int                tx_gap;
  int                rx_hold;
  logic [word_w-1:0] pat [0:7];
  logic [word_w-1:0] tx_words [$];
  logic [word_w-1:0] rx_got [$];
  logic              cap_bits [$];
  status_t           stat_seq [$];

  spi_master dut0 (
    .clk           (clk),
    .rstn          (rstn),
    .clk_div       (clk_div),
    .clk_div_valid (clk_div_valid),
    .rd            (rd),
    .wr            (wr),
    .qrd           (qrd),
    .qwr           (qwr),
    .cmd           (cmd),
    .addr          (addr),
    .cmd_len       (cmd_len),
    .addr_len      (addr_len),
    .data_len      (data_len),
    .dummy_rd      (dummy_rd),
    .dummy_wr      (dummy_wr),
    .cs_mask       (cs_mask),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_ready      (rx_ready),
    .spi_clk       (spi_clk),
    .csn           (csn),
    .mode          (mode),
    .sdo           (sdo),
    .sdi           (sdi),
    .status        (status),
    .eot           (eot)
  );

  always #5 clk = ~clk;

  task automatic show_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("error: %s at %0t", what, $time);
  endtask

  a_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot(status))
    else note_failure("status is not one-hot");

  a_cs_release: assert property (@(posedge clk) disable iff (!rstn) eot |=> csn == {cs_n{1'b1}})
    else show_mismatch("csn", 32'(csn), 32'hf);

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("errors: %0d", errors);
      $display("Done: errors found");
      $finish;
    end
  end

  // per cycle checks on the DUT pins
  always @(posedge clk)
  begin
    tx_took <= tx_valid && tx_ready;
    if (rstn)
    begin
      if (eot)
        eot_cnt++;
      assert (csn == 4'hf || csn == ~cs_mask) else show_mismatch("csn", 32'(csn), 32'(~cs_mask));
      if (status == stat_cmd || status == stat_addr || status == stat_data_tx)
      begin
        assert (mode == (cur_quad ? mode_quad_tx : mode_std))
          else show_mismatch("mode", 32'(mode), 32'(cur_quad ? mode_quad_tx : mode_std));
      end
      else if (status == stat_dummy || status == stat_data_rx)
      begin
        assert (mode == (cur_quad ? mode_quad_rx : mode_std))
          else show_mismatch("mode", 32'(mode), 32'(cur_quad ? mode_quad_rx : mode_std));
      end
      else
      begin
        assert (mode == mode_quad_rx) else show_mismatch("mode", 32'(mode), 32'(mode_quad_rx));
      end
      if (status != last_stat && status != stat_idle)
        stat_seq.push_back(status);
      last_stat = status;
      if (rx_valid && rx_ready)
        rx_got.push_back(rx_data);

      // the clock may finish the word in flight but must stop before the next one completes
      if (rx_valid && !rx_ready)
      begin
        if (spi_clk && !last_spi_clk)
          rx_stall_rises++;
        assert (rx_stall_rises <= 31) else note_failure("spi_clk kept running while rx stalled");
      end
      else
        rx_stall_rises = 0;
      if (status == stat_data_tx && !tx_valid)
      begin
        if (spi_clk && !last_spi_clk)
          tx_stall_rises++;
        assert (tx_stall_rises <= 32) else note_failure("spi_clk kept running while tx stalled");
      end
      else
        tx_stall_rises = 0;

      if (spi_clk != last_spi_clk)
      begin
        if (chk_div && seen_toggle)
          assert (since == cur_div + 1)
            else show_mismatch("spi_clk half period", since, cur_div + 1);
        seen_toggle = 1'b1;
        since = 1;
      end
      else
        since++;
      last_spi_clk = spi_clk;
    end
  end

  // flash slave, samples on the rising SPI edge
  always @(posedge spi_clk)
  begin
    if (csn != 4'hf)
    begin
      rises++;
      if (cur_quad)
      begin
        cap_bits.push_back(sdo[3]);
        cap_bits.push_back(sdo[2]);
        cap_bits.push_back(sdo[1]);
        cap_bits.push_back(sdo[0]);
      end
      else
        cap_bits.push_back(sdo[0]);
    end
  end

  // read data goes out on the falling SPI edge once the header clocks have passed
  always @(negedge spi_clk)
  begin
    int k;
    logic [word_w-1:0] w;
    if (csn != 4'hf && rises >= pre_clocks)
    begin
      k = rises - pre_clocks;
      if (cur_quad)
      begin
        w = pat[(k / 8) % 8];
        sdi = 4'((w >> (28 - 4 * (k % 8))) & 32'hf);
      end
      else
      begin
        w = pat[(k / 32) % 8];
        sdi = {2'b00, w[31 - (k % 32)], 1'b0};
      end
    end
  end

  // a stalled gap outlasts a whole word at clk_div 1, so the clock has to stop
  always @(negedge clk)
  begin
    if (tx_took)
    begin
      tx_valid = 1'b0;
      tx_idx++;
      tx_gap = tx_stall ? 160 + $unsigned($random(seed)) % 64 : 0;
    end
    else if (!tx_valid && tx_idx < tx_n)
    begin
      if (tx_gap == 0)
      begin
        tx_data  = tx_words[tx_idx];
        tx_valid = 1'b1;
      end
      else
        tx_gap--;
    end

    if (!rx_stall)
      rx_ready = 1'b1;
    else if (rx_hold > 0)
      rx_hold--;
    else
    begin
      rx_ready = !rx_ready;
      rx_hold  = rx_ready ? $unsigned($random(seed)) % 8 :
                            256 + $unsigned($random(seed)) % 64;
    end
  end

  task automatic set_div(input int v);
    @(negedge clk);
    clk_div       = div_w'(v);
    clk_div_valid = 1'b1;
    @(negedge clk);
    clk_div_valid = 1'b0;
    cur_div       = v;
  endtask

  task automatic run_txn(input int kind, input logic [31:0] c, input logic [31:0] a,
                         input int clen, input int alen, input int dlen, input int dummy,
                         input logic [3:0] mask);
    int          nw;
    int          i;
    int          nbits;
    int          exp_rises;
    logic        is_rd;
    logic [31:0] exp_w;
    logic        exp_bits [$];
    status_t     exp_seq [$];
    @(negedge clk);
    is_rd      = (kind == k_rd || kind == k_qrd);
    cur_quad   = (kind == k_qwr || kind == k_qrd);
    cmd        = c;
    addr       = a;
    cmd_len    = phase_len_w'(clen);
    addr_len   = phase_len_w'(alen);
    data_len   = len_w'(dlen);
    dummy_rd   = len_w'(dummy);
    dummy_wr   = '0;
    cs_mask    = mask;
    sdi        = '0;
    eot_cnt    = 0;
    rises      = 0;
    seen_toggle = 1'b0;
    tx_gap     = tx_stall ? 160 + $unsigned($random(seed)) % 64 : 0;
    cap_bits.delete();
    rx_got.delete();
    stat_seq.delete();
    nw = (dlen + 31) / 32;
    pre_clocks = cur_quad ? clen / 4 + alen / 4 + dummy : clen + alen + dummy;
    exp_rises  = pre_clocks + (cur_quad ? dlen / 4 : dlen);
    if (is_rd)
    begin
      for (i = 0; i < 8; i++)
        pat[i] = $random(seed);
    end
    else
    begin
      tx_words.delete();
      for (i = 0; i < nw; i++)
        tx_words.push_back($random(seed));
      tx_idx = 0;
      tx_n   = nw;
    end
    rd  = (kind == k_rd);
    wr  = (kind == k_wr);
    qrd = (kind == k_qrd);
    qwr = (kind == k_qwr);
    @(negedge clk);
    rd  = 1'b0;
    wr  = 1'b0;
    qrd = 1'b0;
    qwr = 1'b0;
    while (eot_cnt == 0)
      @(negedge clk);
    repeat (4) @(negedge clk);

    assert (eot_cnt == 1) else note_failure($sformatf("eot pulsed %0d times", eot_cnt));
    assert (csn == 4'hf) else show_mismatch("csn", 32'(csn), 32'hf);
    assert (rises == exp_rises) else show_mismatch("spi_clk rises", rises, exp_rises);
    if (clen != 0)
      exp_seq.push_back(stat_cmd);
    if (alen != 0)
      exp_seq.push_back(stat_addr);
    if (dummy != 0)
      exp_seq.push_back(stat_dummy);
    exp_seq.push_back(is_rd ? stat_data_rx : stat_data_tx);
    assert (stat_seq.size() == exp_seq.size())
      else show_mismatch("status steps", stat_seq.size(), exp_seq.size());
    for (i = 0; i < exp_seq.size() && i < stat_seq.size(); i++)
      assert (stat_seq[i] == exp_seq[i])
        else show_mismatch("status", 32'(stat_seq[i]), 32'(exp_seq[i]));

    if (is_rd)
    begin
      assert (rx_got.size() == nw) else show_mismatch("rx words", rx_got.size(), nw);
      for (i = 0; i < nw && i < rx_got.size(); i++)
      begin
        nbits = (dlen - 32 * i >= 32) ? 32 : dlen - 32 * i;
        exp_w = pat[i] >> (32 - nbits);
        assert (rx_got[i] == exp_w) else show_mismatch("rx_data", rx_got[i], exp_w);
      end
    end
    else
    begin
      for (i = 0; i < clen; i++)
        exp_bits.push_back(c[31 - i]);
      for (i = 0; i < alen; i++)
        exp_bits.push_back(a[31 - i]);
      for (i = 0; i < dlen; i++)
        exp_bits.push_back(tx_words[i / 32][31 - (i % 32)]);
      assert (tx_idx == nw) else show_mismatch("tx words taken", tx_idx, nw);
      assert (cap_bits.size() == exp_bits.size())
        else show_mismatch("sdo bits", cap_bits.size(), exp_bits.size());
      for (i = 0; i < exp_bits.size() && i < cap_bits.size(); i++)
        assert (cap_bits[i] == exp_bits[i]) else show_mismatch($sformatf("sdo bit %0d", i),
                                                                cap_bits[i], exp_bits[i]);
      tx_n = 0;
    end
  endtask

  initial
  begin
    seed = 32'h1e28;
    clk = 1'b0;
    rstn = 1'b0;
    clk_div = '0;
    clk_div_valid = 1'b0;
    rd = 1'b0;
    wr = 1'b0;
    qrd = 1'b0;
    qwr = 1'b0;
    cmd = '0;
    addr = '0;
    cmd_len = '0;
    addr_len = '0;
    data_len = '0;
    dummy_rd = '0;
    dummy_wr = '0;
    cs_mask = '0;
    tx_data = '0;
    tx_valid = 1'b0;
    rx_ready = 1'b1;
    sdi = '0;
    errors = 0;
    cycles = 0;
    tx_idx = 0;
    tx_n = 0;
    tx_gap = 0;
    rx_hold = 0;
    tx_stall = 1'b0;
    rx_stall = 1'b0;
    chk_div = 1'b0;
    cur_quad = 1'b0;
    cur_div = 0;
    pre_clocks = 0;
    last_stat = stat_idle;
    last_spi_clk = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);

    assert (csn == 4'hf) else show_mismatch("csn", 32'(csn), 32'hf);
    assert (spi_clk == 1'b0) else show_mismatch("spi_clk", spi_clk, 0);
    assert (eot == 1'b0) else show_mismatch("eot", eot, 0);
    assert (tx_ready == 1'b0) else show_mismatch("tx_ready", tx_ready, 0);
    assert (rx_valid == 1'b0) else show_mismatch("rx_valid", rx_valid, 0);
    assert (status == stat_idle) else show_mismatch("status", 32'(status), 32'(stat_idle));
    assert (mode == mode_quad_rx) else show_mismatch("mode", 32'(mode), 32'(mode_quad_rx));

    set_div(1);
    run_txn(k_wr, 32'h02a5_0000, 32'h00c3_1e70, 8, 24, 64, 0, 4'b0100);
    run_txn(k_rd, 32'h0b00_0000, 32'h0012_3400, 8, 24, 40, 8, 4'b0001);
    run_txn(k_qwr, 32'h3200_0000, 32'h00ab_cd00, 8, 24, 64, 0, 4'b0010);
    run_txn(k_qrd, 32'heb00_0000, 32'h0055_aa00, 8, 24, 64, 4, 4'b1000);

    // stalls on both data ports
    rx_stall = 1'b1;
    run_txn(k_rd, 32'h0300_0000, 32'h0077_0000, 8, 24, 128, 8, 4'b0001);
    rx_stall = 1'b0;
    tx_stall = 1'b1;
    run_txn(k_wr, 32'h0200_0000, 32'h0010_2000, 8, 24, 96, 0, 4'b0100);
    tx_stall = 1'b0;

    set_div(3);
    chk_div = 1'b1;
    run_txn(k_wr, 32'h0600_0000, 32'h0abc_0000, 8, 24, 64, 0, 4'b0010);
    run_txn(k_wr, 32'h0, 32'h5a5a_0000, 0, 16, 32, 0, 4'b0001);
    chk_div = 1'b0;

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
